// File: hazard_issue_settings.svh
`ifndef HAZARD_ISSUE_SETTINGS_SVH
`define HAZARD_ISSUE_SETTINGS_SVH

// architectural integer registers x0..x31
`define HI_REG_COUNT 32

// cycles a destination stays busy once its producer issues
`define HI_PENDING_DEPTH 3

// kill cycles that follow the trigger cycle
`define HI_KILL_EXTRA 2

`endif

// File: hazard_issue_pkg.sv
package hazard_issue_pkg;

	// raw rv32i instruction word
	typedef logic [31:0] instr_t;

	// major opcode, bits 6:0 of the word
	typedef logic [6:0] opcode_t;

	// architectural register number
	typedef logic [4:0] reg_idx_t;

	// per-register busy countdown, holds 0..HI_PENDING_DEPTH
	typedef logic [1:0] pend_cnt_t;

	// flush window states
	// HOLD1 and HOLD2 are the two cycles after a trigger
	typedef enum logic [1:0]
	{
		FLUSH_IDLE  = 2'd0,
		FLUSH_HOLD1 = 2'd1,
		FLUSH_HOLD2 = 2'd2
	} flush_state_t;

endpackage

// File: instr_decode.sv
module instr_decode
	import hazard_issue_pkg::*;
(
	input  instr_t   instr,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	output reg_idx_t rd,
	output logic     reads_rs1,
	output logic     reads_rs2,
	output logic     writes_rd
);

	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_REG    = 7'b0110011;
	localparam opcode_t OP_SYSTEM = 7'b1110011;

	opcode_t opcode;
	logic    rd_write_raw; // before the x0 check

	// fixed rv32i field positions
	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];

	always_comb
	begin
		case (opcode)
			OP_LUI, OP_AUIPC, OP_JAL:
			begin
				reads_rs1    = 1'b0;
				reads_rs2    = 1'b0;
				rd_write_raw = 1'b1;
			end
			OP_REG:
			begin
				reads_rs1    = 1'b1;
				reads_rs2    = 1'b1;
				rd_write_raw = 1'b1;
			end
			OP_BRANCH, OP_STORE:
			begin
				reads_rs1    = 1'b1;
				reads_rs2    = 1'b1;
				rd_write_raw = 1'b0; // rd bits are immediate here
			end
			OP_JALR, OP_IMM, OP_LOAD, OP_SYSTEM:
			begin
				reads_rs1    = 1'b1;
				reads_rs2    = 1'b0; // rs2 bits are immediate
				rd_write_raw = 1'b1;
			end
			default:
			begin
				reads_rs1    = 1'b0;
				reads_rs2    = 1'b0;
				rd_write_raw = 1'b0;
			end
		endcase
	end

	assign writes_rd = rd_write_raw && (rd != '0); // x0 is never tracked

endmodule

// File: hazard_scoreboard.sv
`include "hazard_issue_settings.svh"

module hazard_scoreboard
	import hazard_issue_pkg::*;
(
	input  logic     clk,
	input  logic     nrst,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  reg_idx_t rd,
	input  logic     reads_rs1,
	input  logic     reads_rs2,
	input  logic     writes_rd,
	input  logic     mark,
	output logic     hazard
);

	localparam int        REG_COUNT  = `HI_REG_COUNT;
	localparam pend_cnt_t PEND_START = pend_cnt_t'(`HI_PENDING_DEPTH);
	localparam pend_cnt_t PEND_STEP  = pend_cnt_t'(1);

	pend_cnt_t            pend_cnt [REG_COUNT];
	pend_cnt_t            pend_next [REG_COUNT];
	logic [REG_COUNT-1:0] busy;
	logic                 mark_en;
	logic                 rs1_busy;
	logic                 rs2_busy;

	// only issuing writers to x1..x31 go in flight
	assign mark_en = mark && writes_rd && (rd != '0);

	always_comb
	begin
		for (int i = 0; i < REG_COUNT; i++)
		begin
			busy[i] = (pend_cnt[i] != '0);
		end
	end

	// mark wins over the decrement on the same register
	always_comb
	begin
		for (int i = 0; i < REG_COUNT; i++)
		begin
			if (mark_en && (rd == reg_idx_t'(i)))
			begin
				pend_next[i] = PEND_START;
			end
			else if (busy[i])
			begin
				pend_next[i] = pend_cnt[i] - PEND_STEP;
			end
			else
			begin
				pend_next[i] = pend_cnt[i];
			end
		end
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < REG_COUNT; i++)
			begin
				pend_cnt[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < REG_COUNT; i++)
			begin
				pend_cnt[i] <= pend_next[i];
			end
		end
	end

	// a source only matters when the instruction reads it
	assign rs1_busy = reads_rs1 && busy[rs1];
	assign rs2_busy = reads_rs2 && busy[rs2];
	assign hazard   = rs1_busy || rs2_busy;

endmodule

// File: flush_control.sv
`include "hazard_issue_settings.svh"

module flush_control
	import hazard_issue_pkg::*;
(
	input  logic clk,
	input  logic nrst,
	input  logic btaken,
	input  logic exception,
	input  logic discard,
	output logic kill
);

	localparam int KILL_EXTRA = `HI_KILL_EXTRA;

	flush_state_t state;
	flush_state_t state_next;
	logic         trigger;
	logic         holding;

	assign trigger = btaken || exception;
	assign holding = (state != FLUSH_IDLE);

	always_comb
	begin
		if (trigger)
		begin
			state_next = FLUSH_HOLD1; // restart the window
		end
		else
		begin
			case (state)
				FLUSH_IDLE:  state_next = FLUSH_IDLE;
				FLUSH_HOLD1: state_next = (KILL_EXTRA > 1) ? FLUSH_HOLD2 : FLUSH_IDLE;
				FLUSH_HOLD2: state_next = FLUSH_IDLE;
				default:     state_next = FLUSH_IDLE;
			endcase
		end
	end

	// window keeps running while discard is high
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state <= FLUSH_IDLE;
		end
		else
		begin
			state <= state_next;
		end
	end

	assign kill = (trigger || holding) && !discard;

endmodule

// File: hazard_issue.sv
module hazard_issue
	import hazard_issue_pkg::*;
(
	input  logic     clk,
	input  logic     nrst,
	input  instr_t   instr,
	input  logic     instr_valid,
	input  logic     btaken,
	input  logic     exception,
	input  logic     discard,
	output logic     issue,
	output logic     stall,
	output logic     kill,
	output reg_idx_t issue_rd
);

	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	logic     reads_rs1;
	logic     reads_rs2;
	logic     writes_rd;
	logic     hazard;

	instr_decode u_instr_decode
	(
		.instr     (instr),
		.rs1       (rs1),
		.rs2       (rs2),
		.rd        (rd),
		.reads_rs1 (reads_rs1),
		.reads_rs2 (reads_rs2),
		.writes_rd (writes_rd)
	);

	hazard_scoreboard u_hazard_scoreboard
	(
		.clk       (clk),
		.nrst      (nrst),
		.rs1       (rs1),
		.rs2       (rs2),
		.rd        (rd),
		.reads_rs1 (reads_rs1),
		.reads_rs2 (reads_rs2),
		.writes_rd (writes_rd),
		.mark      (issue), // killed or stalled words never mark
		.hazard    (hazard)
	);

	flush_control u_flush_control
	(
		.clk       (clk),
		.nrst      (nrst),
		.btaken    (btaken),
		.exception (exception),
		.discard   (discard),
		.kill      (kill)
	);

	// kill has priority over stall
	assign stall = instr_valid && hazard && !kill;
	assign issue = instr_valid && !stall && !kill;

	assign issue_rd = (issue && writes_rd) ? rd : '0;

endmodule

// File: hazard_issue_assertions.sv
module hazard_issue_assertions
(
	input logic clk,
	input logic nrst,
	input logic btaken,
	input logic exception,
	input logic issue,
	input logic stall,
	input logic kill
);

	timeunit 1ns;
	timeprecision 1ps;

	logic trigger;

	assign trigger = btaken || exception;

	stall_kill_exclusive: assert property (@(posedge clk) disable iff (!nrst)
		!(stall && kill))
		else $error("stall and kill are high together");

	issue_clean: assert property (@(posedge clk) disable iff (!nrst)
		issue |-> (!stall && !kill))
		else $error("issue while stall or kill is high");

	// kill may only trail a trigger by up to two cycles
	kill_window: assert property (@(posedge clk) disable iff (!nrst)
		(kill && !trigger) |-> ($past(trigger, 1) || $past(trigger, 2)))
		else $error("kill outside the window after a trigger");

endmodule

bind hazard_issue hazard_issue_assertions u_hazard_issue_assertions
(
	.clk       (clk),
	.nrst      (nrst),
	.btaken    (btaken),
	.exception (exception),
	.issue     (issue),
	.stall     (stall),
	.kill      (kill)
);

// File: tb_hazard_issue.sv
`include "hazard_issue_settings.svh"

module tb_hazard_issue
	import hazard_issue_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD  = 100;
	localparam int RAND_CYCLES = 300;
	localparam int TEST_CYCLES = 16 + 120 + RAND_CYCLES; // reset, directed, random
	localparam int MARGIN      = 100;

	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_REG    = 7'b0110011;
	localparam opcode_t OP_SYSTEM = 7'b1110011;
	localparam opcode_t OP_BAD    = 7'b1111111;
	localparam opcode_t OP_POOL [10] = '{OP_LUI, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD,
		OP_STORE, OP_IMM, OP_REG, OP_SYSTEM, OP_BAD};

	logic     clk;
	logic     nrst;
	instr_t   instr;
	logic     instr_valid;
	logic     btaken;
	logic     exception;
	logic     discard;
	logic     issue;
	logic     stall;
	logic     kill;
	reg_idx_t issue_rd;

	int       ref_cnt [`HI_REG_COUNT]; // model of the busy countdowns
	int       ref_hold;                // kill cycles left after a trigger
	logic     s_issue;
	logic     s_stall;
	logic     s_kill;
	reg_idx_t s_rd;

	hazard_issue u_hazard_issue
	(
		.clk         (clk),
		.nrst        (nrst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.btaken      (btaken),
		.exception   (exception),
		.discard     (discard),
		.issue       (issue),
		.stall       (stall),
		.kill        (kill),
		.issue_rd    (issue_rd)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
		if (act !== exp)
		begin
			$display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
			stop_run();
		end
	endtask

	function automatic instr_t build_instr(input opcode_t op, input reg_idx_t rd,
		input reg_idx_t rs1, input reg_idx_t rs2);
		return {7'd0, rs2, rs1, 3'd0, rd, op};
	endfunction

	// read and write flags per the rv32i opcode table
	task automatic classify(input instr_t w, output logic r1, output logic r2, output logic wr);
		case (w[6:0])
			OP_LUI, 7'b0010111, OP_JAL:                 {r1, r2, wr} = 3'b001;
			OP_REG:                                     {r1, r2, wr} = 3'b111;
			OP_BRANCH, OP_STORE:                        {r1, r2, wr} = 3'b110;
			OP_JALR, OP_IMM, OP_LOAD, OP_SYSTEM:        {r1, r2, wr} = 3'b101;
			default:                                    {r1, r2, wr} = 3'b000;
		endcase
		wr = wr && (w[11:7] != 5'd0);
	endtask

	// drive and check one clock, then step the model at posedge
	task automatic cycle(input instr_t w, input logic v, input logic bt, input logic ex,
		input logic dc);
		logic     r1;
		logic     r2;
		logic     wr;
		logic     hz;
		logic     exp_issue;
		logic     exp_stall;
		logic     exp_kill;
		reg_idx_t exp_rd;
		@(negedge clk);
		instr = w;
		instr_valid = v;
		btaken = bt;
		exception = ex;
		discard = dc;
		classify(w, r1, r2, wr);
		hz = (r1 && ref_cnt[w[19:15]] != 0) || (r2 && ref_cnt[w[24:20]] != 0);
		exp_kill = (bt || ex || ref_hold != 0) && !dc;
		exp_stall = v && hz && !exp_kill;
		exp_issue = v && !exp_stall && !exp_kill;
		exp_rd = (exp_issue && wr) ? w[11:7] : 5'd0;
		#(CLK_PERIOD / 10);
		s_issue = issue;
		s_stall = stall;
		s_kill = kill;
		s_rd = issue_rd;
		check_bit("kill", exp_kill, kill);
		check_bit("stall", exp_stall, stall);
		check_bit("issue", exp_issue, issue);
		check_idx("issue_rd", exp_rd, issue_rd);
		@(posedge clk);
		for (int i = 0; i < `HI_REG_COUNT; i++)
		begin
			if (ref_cnt[i] != 0)
				ref_cnt[i]--;
		end
		if (exp_issue && wr)
			ref_cnt[w[11:7]] = `HI_PENDING_DEPTH; // mark beats decrement
		if (bt || ex)
			ref_hold = `HI_KILL_EXTRA;
		else if (ref_hold != 0)
			ref_hold--;
	endtask

	task automatic idle(input int n);
		repeat (n) cycle('0, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic cycle_kill(input instr_t w, input logic bt, input logic ex, input logic dc,
		input logic exp_kill);
		cycle(w, 1'b1, bt, ex, dc);
		check_bit("kill", exp_kill, s_kill);
	endtask

	task automatic test_independent();
		cycle(build_instr(OP_IMM, 5'd1, 5'd2, 5'd0), 1'b1, 1'b0, 1'b0, 1'b0);
		check_bit("issue", 1'b1, s_issue);
		check_idx("issue_rd", 5'd1, s_rd);
		cycle(build_instr(OP_REG, 5'd3, 5'd4, 5'd5), 1'b1, 1'b0, 1'b0, 1'b0);
		check_idx("issue_rd", 5'd3, s_rd);
		cycle(build_instr(OP_LUI, 5'd6, 5'd1, 5'd3), 1'b1, 1'b0, 1'b0, 1'b0);
		check_idx("issue_rd", 5'd6, s_rd);
		idle(3);
	endtask

	task automatic test_raw(input logic on_rs2);
		instr_t consumer;
		consumer = on_rs2 ? build_instr(OP_REG, 5'd8, 5'd0, 5'd7) :
			build_instr(OP_REG, 5'd8, 5'd7, 5'd0);
		cycle(build_instr(OP_REG, 5'd7, 5'd1, 5'd2), 1'b1, 1'b0, 1'b0, 1'b0);
		repeat (3)
		begin
			cycle(consumer, 1'b1, 1'b0, 1'b0, 1'b0);
			check_bit("stall", 1'b1, s_stall);
		end
		cycle(consumer, 1'b1, 1'b0, 1'b0, 1'b0);
		check_bit("issue", 1'b1, s_issue);
		idle(3);
	endtask

	task automatic test_decode();
		cycle(build_instr(OP_STORE, 5'd10, 5'd1, 5'd2), 1'b1, 1'b0, 1'b0, 1'b0);
		cycle(build_instr(OP_REG, 5'd11, 5'd10, 5'd0), 1'b1, 1'b0, 1'b0, 1'b0);
		check_bit("stall", 1'b0, s_stall);
		cycle(build_instr(OP_REG, 5'd12, 5'd1, 5'd2), 1'b1, 1'b0, 1'b0, 1'b0);
		cycle(build_instr(OP_IMM, 5'd13, 5'd0, 5'd12), 1'b1, 1'b0, 1'b0, 1'b0); // rs2 is imm
		check_bit("stall", 1'b0, s_stall);
		cycle(build_instr(OP_REG, 5'd0, 5'd1, 5'd2), 1'b1, 1'b0, 1'b0, 1'b0);
		check_idx("issue_rd", 5'd0, s_rd);
		cycle(build_instr(OP_REG, 5'd14, 5'd0, 5'd0), 1'b1, 1'b0, 1'b0, 1'b0);
		check_bit("stall", 1'b0, s_stall);
		cycle(build_instr(OP_BAD, 5'd15, 5'd14, 5'd14), 1'b1, 1'b0, 1'b0, 1'b0); // x14 busy
		check_bit("stall", 1'b0, s_stall);
		check_idx("issue_rd", 5'd0, s_rd);
		cycle(build_instr(OP_REG, 5'd16, 5'd15, 5'd15), 1'b1, 1'b0, 1'b0, 1'b0);
		check_bit("stall", 1'b0, s_stall);
		idle(3);
	endtask

	task automatic test_kill();
		instr_t w;
		cycle_kill(build_instr(OP_REG, 5'd17, 5'd1, 5'd2), 1'b1, 1'b0, 1'b0, 1'b1);
		cycle_kill(build_instr(OP_REG, 5'd18, 5'd1, 5'd2), 1'b0, 1'b0, 1'b0, 1'b1);
		cycle_kill(build_instr(OP_REG, 5'd19, 5'd1, 5'd2), 1'b0, 1'b0, 1'b0, 1'b1);
		cycle_kill(build_instr(OP_REG, 5'd20, 5'd17, 5'd18), 1'b0, 1'b0, 1'b0, 1'b0);
		check_bit("stall", 1'b0, s_stall); // killed words left no mark
		w = build_instr(OP_IMM, 5'd21, 5'd0, 5'd0);
		cycle_kill(w, 1'b1, 1'b0, 1'b0, 1'b1);
		cycle_kill(w, 1'b0, 1'b0, 1'b0, 1'b1);
		cycle_kill(w, 1'b1, 1'b0, 1'b0, 1'b1); // restart inside the window
		cycle_kill(w, 1'b0, 1'b0, 1'b0, 1'b1);
		cycle_kill(w, 1'b0, 1'b0, 1'b0, 1'b1);
		cycle_kill(w, 1'b0, 1'b0, 1'b0, 1'b0);
		idle(3);
	endtask

	task automatic test_discard();
		instr_t w;
		w = build_instr(OP_LUI, 5'd22, 5'd0, 5'd0);
		cycle_kill(w, 1'b0, 1'b1, 1'b0, 1'b1);
		cycle_kill(w, 1'b0, 1'b0, 1'b1, 1'b0);
		cycle_kill(w, 1'b0, 1'b0, 1'b0, 1'b1);
		cycle_kill(w, 1'b0, 1'b0, 1'b0, 1'b0);
		cycle_kill(w, 1'b1, 1'b0, 1'b1, 1'b0);
		cycle_kill(w, 1'b0, 1'b0, 1'b0, 1'b1);
		cycle_kill(w, 1'b0, 1'b0, 1'b0, 1'b1);
		cycle_kill(w, 1'b0, 1'b0, 1'b0, 1'b0);
		idle(3);
	endtask

	task automatic test_random();
		instr_t w;
		logic   v;
		w = '0;
		v = 1'b0;
		for (int n = 0; n < RAND_CYCLES; n++)
		begin
			if (!s_stall) // upstream holds the word while stalled
			begin
				w = build_instr(OP_POOL[$urandom_range(0, 9)], reg_idx_t'($urandom_range(0, 7)),
					reg_idx_t'($urandom_range(0, 7)), reg_idx_t'($urandom_range(0, 7)));
				v = ($urandom_range(0, 3) != 0);
			end
			cycle(w, v, ($urandom_range(0, 24) == 0), ($urandom_range(0, 49) == 0),
				($urandom_range(0, 9) == 0));
		end
	endtask

	initial
	begin
		#((TEST_CYCLES + MARGIN) * CLK_PERIOD);
		$display("watchdog expired before the tests completed");
		stop_run();
	end

	initial
	begin
		clk = 1'b0;
		nrst = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		btaken = 1'b0;
		exception = 1'b0;
		discard = 1'b0;
		void'($urandom(70));
		for (int i = 0; i < `HI_REG_COUNT; i++)
			ref_cnt[i] = 0;
		ref_hold = 0;
		s_stall = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		instr = build_instr(OP_REG, 5'd0, 5'd1, 5'd2); // reads x1 and x2, writes nothing
		instr_valid = 1'b1;
		#(CLK_PERIOD / 10);
		check_bit("stall", 1'b0, stall);
		check_bit("kill", 1'b0, kill);
		check_bit("issue", 1'b1, issue);
		test_independent();
		test_raw(1'b0);
		test_raw(1'b1);
		test_decode();
		test_kill();
		test_discard();
		test_random();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: hazard_issue.f
+incdir+.
hazard_issue_pkg.sv
instr_decode.sv
hazard_scoreboard.sv
flush_control.sv
hazard_issue.sv
hazard_issue_assertions.sv
tb_hazard_issue.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_hazard_issue
FILELIST  = hazard_issue.f
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
